// File: Bender.yml
package:
  name: icache_fill

sources:
  - files:
      - hdl/lce_pkg.sv
      - hdl/lce_two_fifo.sv
      - hdl/lce_data_cmd.sv
      - hdl/data_mem_port.sv
      - hdl/data_way_bank.sv
      - hdl/read_collect.sv
      - hdl/icache_fill_top.sv

  - target: simulation
    files:
      - tb/tb_icache_fill.sv

// File: filelist.f
hdl/lce_pkg.sv
hdl/lce_two_fifo.sv
hdl/lce_data_cmd.sv
hdl/data_mem_port.sv
hdl/data_way_bank.sv
hdl/read_collect.sv
hdl/icache_fill_top.sv
tb/tb_icache_fill.sv

// File: hdl/data_mem_port.sv
// Single port to the data memory banks, shared by fetch reads and block fills.
// Reads always win, so a steady read stream starves fills.
`default_nettype none

module data_mem_port
  ( input  logic                                rd_v_i
  , input  logic [lce_pkg::index_width-1:0]     rd_addr_i

  , input  logic                                mem_pkt_v_i
  , input  logic [lce_pkg::index_width-1:0]     mem_pkt_index_i
  , input  logic [lce_pkg::way_width-1:0]       mem_pkt_way_i
  , input  logic [lce_pkg::lce_data_width-1:0]  mem_pkt_data_i
  , output logic                                mem_pkt_yumi_o

  , output logic [lce_pkg::index_width-1:0]     bank_index_o
  , output logic [lce_pkg::lce_data_width-1:0]  bank_wdata_o
  , output logic [lce_pkg::ways-1:0]            bank_we_o
  , output logic                                bank_re_o
  );

  // a fill is taken only in a cycle with no read.
  assign mem_pkt_yumi_o = mem_pkt_v_i & ~rd_v_i;

  // read strobe goes to every bank; the collector picks the way later.
  assign bank_re_o = rd_v_i;

  // shared index follows whoever owns the port.
  assign bank_index_o = rd_v_i ? rd_addr_i : mem_pkt_index_i;

  // the whole block is written, so data goes out unchanged.
  assign bank_wdata_o = mem_pkt_data_i;

  // way id to one-hot bank write enable.
  always_comb begin
    bank_we_o = '0;
    if (mem_pkt_yumi_o) begin
      bank_we_o[mem_pkt_way_i] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/data_way_bank.sv
// Block storage for one way. Reads are registered and the output holds the
// last block read until the next read. No reset on the array or the output.
`default_nettype none

module data_way_bank
  ( input  logic                                clk_i
  , input  logic [lce_pkg::index_width-1:0]     index_i
  , input  logic [lce_pkg::lce_data_width-1:0]  wdata_i
  , input  logic                                we_i
  , input  logic                                re_i
  , output logic [lce_pkg::lce_data_width-1:0]  rdata_o
  );

  import lce_pkg::*;

  logic [lce_data_width-1:0] mem_r [sets];

  // whole-block write.
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_r[index_i] <= wdata_i;
    end
  end

  // registered read, old contents on a same-edge write.
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_r[index_i];
    end
  end

  // the arbiter upstream never grants both in one cycle.
  a_no_read_write_overlap : assert property (@(posedge clk_i)
    !(we_i && re_i));

endmodule

`default_nettype wire

// File: hdl/icache_fill_top.sv
// Fill side of the instruction cache: data command buffer, block writer, port
// arbiter, one bank per way and the read collector. Tags and miss tracking
// live elsewhere; miss_addr_i must be held stable while fills for it are pending.
`default_nettype none

module icache_fill_top
  ( input  logic                                clk_i
  , input  logic                                reset_i

  , input  logic [lce_pkg::paddr_width-1:0]     miss_addr_i

  , input  lce_pkg::lce_data_cmd_type_e         data_cmd_type_i
  , input  logic [lce_pkg::way_width-1:0]       data_cmd_way_i
  , input  logic [lce_pkg::lce_data_width-1:0]  data_cmd_data_i
  , input  logic                                data_cmd_v_i
  , output logic                                data_cmd_ready_o

  , output logic                                cce_data_received_o
  , output logic                                tr_data_received_o

  , input  logic                                rd_v_i
  , input  logic [lce_pkg::paddr_width-1:0]     rd_addr_i
  , input  logic [lce_pkg::way_width-1:0]       rd_way_i
  , output logic [lce_pkg::data_width-1:0]      rd_data_o
  , output logic                                rd_data_v_o
  );

  import lce_pkg::*;

  logic                          mem_pkt_v;
  logic [index_width-1:0]        mem_pkt_index;
  logic [way_width-1:0]          mem_pkt_way;
  logic [lce_data_width-1:0]     mem_pkt_data;
  logic                          mem_pkt_yumi;

  logic [index_width-1:0]        bank_index;
  logic [lce_data_width-1:0]     bank_wdata;
  logic [ways-1:0]               bank_we;
  logic                          bank_re;
  logic [ways*lce_data_width-1:0] bank_rdata;

  logic [index_width-1:0]        rd_index;
  logic [word_offset_width-1:0]  rd_word;

  // fetch address split; byte offset is dropped.
  assign rd_index = rd_addr_i[block_offset_width +: index_width];
  assign rd_word  = rd_addr_i[byte_offset_width +: word_offset_width];

  lce_data_cmd i_lce_data_cmd
    ( .clk_i               (clk_i)
    , .reset_i             (reset_i)
    , .miss_addr_i         (miss_addr_i)
    , .data_cmd_type_i     (data_cmd_type_i)
    , .data_cmd_way_i      (data_cmd_way_i)
    , .data_cmd_data_i     (data_cmd_data_i)
    , .data_cmd_v_i        (data_cmd_v_i)
    , .data_cmd_ready_o    (data_cmd_ready_o)
    , .mem_pkt_v_o         (mem_pkt_v)
    , .mem_pkt_index_o     (mem_pkt_index)
    , .mem_pkt_way_o       (mem_pkt_way)
    , .mem_pkt_data_o      (mem_pkt_data)
    , .mem_pkt_yumi_i      (mem_pkt_yumi)
    , .cce_data_received_o (cce_data_received_o)
    , .tr_data_received_o  (tr_data_received_o)
    );

  data_mem_port i_data_mem_port
    ( .rd_v_i          (rd_v_i)
    , .rd_addr_i       (rd_index)
    , .mem_pkt_v_i     (mem_pkt_v)
    , .mem_pkt_index_i (mem_pkt_index)
    , .mem_pkt_way_i   (mem_pkt_way)
    , .mem_pkt_data_i  (mem_pkt_data)
    , .mem_pkt_yumi_o  (mem_pkt_yumi)
    , .bank_index_o    (bank_index)
    , .bank_wdata_o    (bank_wdata)
    , .bank_we_o       (bank_we)
    , .bank_re_o       (bank_re)
    );

  // one bank per way, all read together.
  for (genvar w = 0; w < ways; w++) begin : g_bank
    data_way_bank i_data_way_bank
      ( .clk_i   (clk_i)
      , .index_i (bank_index)
      , .wdata_i (bank_wdata)
      , .we_i    (bank_we[w])
      , .re_i    (bank_re)
      , .rdata_o (bank_rdata[w*lce_data_width +: lce_data_width])
      );
  end

  read_collect i_read_collect
    ( .clk_i        (clk_i)
    , .reset_i      (reset_i)
    , .rd_v_i       (rd_v_i)
    , .rd_way_i     (rd_way_i)
    , .rd_word_i    (rd_word)
    , .bank_rdata_i (bank_rdata)
    , .rd_data_o    (rd_data_o)
    , .rd_data_v_o  (rd_data_v_o)
    );

endmodule

`default_nettype wire

// File: hdl/lce_data_cmd.sv
// Turns buffered data command messages into whole-block writes to the data memory.
// The set index comes from miss_addr_i, which must hold the outstanding miss
// for as long as a message for it is pending.
`default_nettype none

module lce_data_cmd
  ( input  logic                                 clk_i
  , input  logic                                 reset_i

  , input  logic [lce_pkg::paddr_width-1:0]      miss_addr_i

  , input  lce_pkg::lce_data_cmd_type_e          data_cmd_type_i
  , input  logic [lce_pkg::way_width-1:0]        data_cmd_way_i
  , input  logic [lce_pkg::lce_data_width-1:0]   data_cmd_data_i
  , input  logic                                 data_cmd_v_i
  , output logic                                 data_cmd_ready_o

  , output logic                                 mem_pkt_v_o
  , output logic [lce_pkg::index_width-1:0]      mem_pkt_index_o
  , output logic [lce_pkg::way_width-1:0]        mem_pkt_way_o
  , output logic [lce_pkg::lce_data_width-1:0]   mem_pkt_data_o
  , input  logic                                 mem_pkt_yumi_i

  , output logic                                 cce_data_received_o
  , output logic                                 tr_data_received_o
  );

  import lce_pkg::*;

  logic [data_cmd_width-1:0] fifo_data_li;
  logic [data_cmd_width-1:0] fifo_data_lo;
  logic                      fifo_v_lo;
  lce_data_cmd_type_e        cmd_type_lo;

  // network side is ready/valid, the memory side wants valid/yumi.
  assign fifo_data_li = {data_cmd_type_i, data_cmd_way_i, data_cmd_data_i};

  lce_two_fifo i_rv_adapter
    ( .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .data_i  (fifo_data_li)
    , .v_i     (data_cmd_v_i)
    , .ready_o (data_cmd_ready_o)
    , .data_o  (fifo_data_lo)
    , .v_o     (fifo_v_lo)
    , .yumi_i  (mem_pkt_yumi_i)
    );

  // unpack the head entry.
  assign cmd_type_lo    = lce_data_cmd_type_e'(fifo_data_lo[data_cmd_width-1]);
  assign mem_pkt_way_o  = fifo_data_lo[lce_data_width +: way_width];
  assign mem_pkt_data_o = fifo_data_lo[lce_data_width-1:0];

  // set index sits just above the block offset.
  assign mem_pkt_index_o = miss_addr_i[block_offset_width +: index_width];
  assign mem_pkt_v_o     = fifo_v_lo;

  // one pulse per block written, split by where the data came from.
  assign cce_data_received_o = mem_pkt_yumi_i & (cmd_type_lo == e_lce_data_cmd_cce);
  assign tr_data_received_o  = mem_pkt_yumi_i & (cmd_type_lo == e_lce_data_cmd_transfer);

endmodule

`default_nettype wire

// File: hdl/lce_pkg.sv
// Geometry of the instruction cache fill path.
// A block holds one fetch word per way, so ways also sets the words per block.
// All sizes must be powers of two.
`default_nettype none

package lce_pkg;

  // message type carried on the data command channel.
  typedef enum logic [0:0] {
    e_lce_data_cmd_transfer = 1'b0,
    e_lce_data_cmd_cce      = 1'b1
  } lce_data_cmd_type_e;

  // fetch word and cache shape.
  localparam int data_width  = 32;
  localparam int ways        = 4;
  localparam int sets        = 16;
  localparam int paddr_width = 16;

  // one block is one word per way.
  localparam int lce_data_width = ways * data_width;

  // address fields below the set index.
  // paddr = {tag, index, word offset, byte offset}.
  localparam int word_offset_width  = $clog2(ways);
  localparam int byte_offset_width  = $clog2(data_width / 8);
  localparam int block_offset_width = word_offset_width + byte_offset_width;
  localparam int index_width        = $clog2(sets);

  // way id as carried in the message.
  localparam int way_width = $clog2(ways);

  // one buffered message, packed as {type, way, data}.
  localparam int data_cmd_width = $bits(lce_data_cmd_type_e) + way_width + lce_data_width;

endpackage

`default_nettype wire

// File: hdl/lce_two_fifo.sv
// Two-entry buffer, ready/valid on the input side and valid/yumi on the output side.
// yumi_i may only be raised while v_o is high. Full throughput with one entry held.
`default_nettype none

module lce_two_fifo
  ( input  logic                              clk_i
  , input  logic                              reset_i

  , input  logic [lce_pkg::data_cmd_width-1:0] data_i
  , input  logic                              v_i
  , output logic                              ready_o

  , output logic [lce_pkg::data_cmd_width-1:0] data_o
  , output logic                              v_o
  , input  logic                              yumi_i
  );

  import lce_pkg::*;

  logic [data_cmd_width-1:0] mem_r [2];
  logic wptr_r, rptr_r;
  logic full_r, empty_r;
  logic enq, deq;

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rptr_r];

  // pointers and occupancy.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end else begin
      if (enq) wptr_r <= ~wptr_r;
      if (deq) rptr_r <= ~rptr_r;
      // simultaneous push and pop leaves the occupancy unchanged.
      if (enq && !deq) begin
        empty_r <= 1'b0;
        full_r  <= (~wptr_r == rptr_r);
      end else if (deq && !enq) begin
        full_r  <= 1'b0;
        empty_r <= (~rptr_r == wptr_r);
      end
    end
  end

  // payload slots.
  always_ff @(posedge clk_i) begin
    if (enq) mem_r[wptr_r] <= data_i;
  end

  // the consumer must never pop an empty buffer.
  a_no_yumi_when_empty : assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

// File: hdl/read_collect.sv
// Picks one fetch word out of the blocks returned by all banks.
// Output is valid for one cycle, the cycle after the read was presented.
`default_nettype none

module read_collect
  ( input  logic                                        clk_i
  , input  logic                                        reset_i

  , input  logic                                        rd_v_i
  , input  logic [lce_pkg::way_width-1:0]               rd_way_i
  , input  logic [lce_pkg::word_offset_width-1:0]       rd_word_i

  , input  logic [lce_pkg::ways*lce_pkg::lce_data_width-1:0] bank_rdata_i

  , output logic [lce_pkg::data_width-1:0]              rd_data_o
  , output logic                                        rd_data_v_o
  );

  import lce_pkg::*;

  logic                         rd_v_r;
  logic [way_width-1:0]         way_r;
  logic [word_offset_width-1:0] word_r;
  logic [lce_data_width-1:0]    block_sel;

  // valid is control state.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_v_r <= 1'b0;
    end else begin
      rd_v_r <= rd_v_i;
    end
  end

  // selects line up with the banks' registered read.
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      way_r  <= rd_way_i;
      word_r <= rd_word_i;
    end
  end

  // bank first, then word within the block.
  assign block_sel   = bank_rdata_i[way_r * lce_data_width +: lce_data_width];
  assign rd_data_o   = block_sel[word_r * data_width +: data_width];
  assign rd_data_v_o = rd_v_r;

endmodule

`default_nettype wire

// File: tb/tb_icache_fill.sv
// Directed tests for the fill side of the instruction cache.
// The miss address is only changed while no fill is pending, and reads only target
// blocks that a fill has written.
`default_nettype none

module tb_icache_fill;

  import lce_pkg::*;

  localparam int test_cycles  = 700;
  localparam int reset_cycles = 16;
  localparam logic [index_width-1:0] fill_set = 4'd5;
  localparam logic [index_width-1:0] bp_set   = 4'd9;
  localparam logic [way_width-1:0]   bp_way   = 2'd2;

  logic                       clk;
  logic                       reset_i;
  logic [paddr_width-1:0]     miss_addr_i;
  lce_data_cmd_type_e         data_cmd_type_i;
  logic [way_width-1:0]       data_cmd_way_i;
  logic [lce_data_width-1:0]  data_cmd_data_i;
  logic                       data_cmd_v_i;
  logic                       data_cmd_ready_o;
  logic                       cce_data_received_o;
  logic                       tr_data_received_o;
  logic                       rd_v_i;
  logic [paddr_width-1:0]     rd_addr_i;
  logic [way_width-1:0]       rd_way_i;
  logic [data_width-1:0]      rd_data_o;
  logic                       rd_data_v_o;

  int                         errors;
  int                         cce_cnt;
  int                         tr_cnt;
  logic [31:0]                seed;
  logic                       prev_rd_v;
  logic [data_width-1:0]      exp_word;

  // reference model of the banks, plus the messages accepted but not yet written.
  logic [lce_data_width-1:0]  model [sets][ways];
  bit                         written [sets][ways];
  logic [index_width-1:0]     pend_index [$];
  logic [way_width-1:0]       pend_way [$];
  logic [lce_data_width-1:0]  pend_data [$];
  lce_data_cmd_type_e         pend_type [$];

  icache_fill_top i_icache_fill_top (
    .clk_i               (clk),
    .reset_i             (reset_i),
    .miss_addr_i         (miss_addr_i),
    .data_cmd_type_i     (data_cmd_type_i),
    .data_cmd_way_i      (data_cmd_way_i),
    .data_cmd_data_i     (data_cmd_data_i),
    .data_cmd_v_i        (data_cmd_v_i),
    .data_cmd_ready_o    (data_cmd_ready_o),
    .cce_data_received_o (cce_data_received_o),
    .tr_data_received_o  (tr_data_received_o),
    .rd_v_i              (rd_v_i),
    .rd_addr_i           (rd_addr_i),
    .rd_way_i            (rd_way_i),
    .rd_data_o           (rd_data_o),
    .rd_data_v_o         (rd_data_v_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [lce_data_width-1:0] exp,
                                 input logic [lce_data_width-1:0] act);
    errors++;
    $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, act);
  endtask

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [lce_data_width-1:0] rand_block();
    logic [lce_data_width-1:0] b;
    for (int i = 0; i < ways; i++) begin
      b[i*data_width +: data_width] = next_rand();
    end
    return b;
  endfunction

  // address layout is {tag, index, word offset, byte offset}.
  function automatic logic [paddr_width-1:0] make_addr(input logic [7:0] tag,
      input logic [index_width-1:0] set, input logic [word_offset_width-1:0] word);
    return {tag, set, word, 2'b00};
  endfunction

  // response checks and model updates, sampled mid-cycle.
  always @(negedge clk) begin
    if (reset_i) begin
      prev_rd_v = 1'b0;
    end else begin
      if (rd_data_v_o !== prev_rd_v) begin
        report_mismatch("rd_data_v_o", prev_rd_v, rd_data_v_o);
      end else if (prev_rd_v && rd_data_o !== exp_word) begin
        report_mismatch("rd_data_o", exp_word, rd_data_o);
      end
      if (cce_data_received_o && tr_data_received_o) begin
        errors++;
        $display("ERROR: both received flags high at t=%0t", $time);
      end
      if (cce_data_received_o || tr_data_received_o) begin
        if (pend_way.size() == 0) begin
          errors++;
          $display("ERROR: received pulse at t=%0t with no message pending", $time);
        end else begin
          if (cce_data_received_o !== (pend_type[0] == e_lce_data_cmd_cce)) begin
            report_mismatch("cce_data_received_o", pend_type[0] == e_lce_data_cmd_cce,
                            cce_data_received_o);
          end
          model[pend_index[0]][pend_way[0]] = pend_data[0];
          written[pend_index[0]][pend_way[0]] = 1'b1;
          void'(pend_index.pop_front());
          void'(pend_way.pop_front());
          void'(pend_data.pop_front());
          void'(pend_type.pop_front());
        end
        if (cce_data_received_o) cce_cnt++;
        if (tr_data_received_o) tr_cnt++;
      end
      // accepted on the coming edge.
      if (data_cmd_v_i && data_cmd_ready_o) begin
        pend_index.push_back(miss_addr_i[block_offset_width +: index_width]);
        pend_way.push_back(data_cmd_way_i);
        pend_data.push_back(data_cmd_data_i);
        pend_type.push_back(data_cmd_type_i);
      end
      prev_rd_v = rd_v_i;
      if (rd_v_i) begin
        exp_word = model[rd_addr_i[block_offset_width +: index_width]][rd_way_i]
                        [rd_addr_i[byte_offset_width +: word_offset_width]*data_width +: data_width];
      end
    end
  end

  task automatic send_msg(input lce_data_cmd_type_e t, input logic [way_width-1:0] way,
                          input logic [lce_data_width-1:0] data);
    int waited;
    waited = 0;
    @(posedge clk);
    data_cmd_v_i    <= 1'b1;
    data_cmd_type_i <= t;
    data_cmd_way_i  <= way;
    data_cmd_data_i <= data;
    @(negedge clk);
    while (!data_cmd_ready_o && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    if (!data_cmd_ready_o) begin
      errors++;
      $display("ERROR: message offered at t=%0t was never accepted", $time);
    end
    @(posedge clk);
    data_cmd_v_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk);
    while (pend_way.size() != 0 && waited < 50) begin
      @(posedge clk);
      waited++;
    end
    if (pend_way.size() != 0) begin
      errors++;
      $display("ERROR: fills still pending at t=%0t after 50 cycles", $time);
    end
  endtask

  task automatic read_word(input logic [index_width-1:0] set, input logic [way_width-1:0] way,
                           input logic [word_offset_width-1:0] word,
                           output logic [data_width-1:0] got);
    int waited;
    logic [31:0] r;
    waited = 0;
    r = next_rand();
    @(posedge clk);
    rd_v_i    <= 1'b1;
    rd_addr_i <= make_addr(r[7:0], set, word);
    rd_way_i  <= way;
    @(posedge clk);
    rd_v_i <= 1'b0;
    @(negedge clk);
    while (!rd_data_v_o && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!rd_data_v_o) begin
      errors++;
      $display("ERROR: no read response at t=%0t", $time);
    end
    got = rd_data_o;
  endtask

  task automatic check_reset();
    @(negedge clk);
    if (data_cmd_ready_o !== 1'b1) report_mismatch("data_cmd_ready_o", 1, data_cmd_ready_o);
    if (rd_data_v_o !== 1'b0) report_mismatch("rd_data_v_o", 0, rd_data_v_o);
    if (cce_data_received_o !== 1'b0) begin
      report_mismatch("cce_data_received_o", 0, cce_data_received_o);
    end
    if (tr_data_received_o !== 1'b0) report_mismatch("tr_data_received_o", 0, tr_data_received_o);
  endtask

  task automatic fill_and_readback();
    logic [lce_data_width-1:0] sent [ways];
    logic [data_width-1:0]     got;
    @(posedge clk);
    miss_addr_i <= make_addr(8'h3c, fill_set, 2'd0);
    for (int w = 0; w < ways; w++) begin
      sent[w] = rand_block();
      send_msg(e_lce_data_cmd_cce, way_width'(w), sent[w]);
    end
    wait_drain();
    for (int w = 0; w < ways; w++) begin
      for (int k = 0; k < ways; k++) begin
        read_word(fill_set, way_width'(w), word_offset_width'(k), got);
        if (got !== sent[w][k*data_width +: data_width]) begin
          report_mismatch("rd_data_o", sent[w][k*data_width +: data_width], got);
        end
      end
    end
  endtask

  task automatic count_flags();
    int n_cce;
    int n_tr;
    int base_cce;
    int base_tr;
    logic [31:0] r;
    n_cce = 0;
    n_tr  = 0;
    @(posedge clk);
    miss_addr_i <= make_addr(8'h71, 4'd12, 2'd0);
    base_cce = cce_cnt;
    base_tr  = tr_cnt;
    repeat (8) begin
      r = next_rand();
      if (r[0]) n_cce++;
      else n_tr++;
      send_msg(lce_data_cmd_type_e'(r[0]), r[5:4], rand_block());
    end
    wait_drain();
    if (cce_cnt - base_cce != n_cce) report_mismatch("cce pulse count", n_cce, cce_cnt - base_cce);
    if (tr_cnt - base_tr != n_tr) report_mismatch("tr pulse count", n_tr, tr_cnt - base_tr);
  endtask

  task automatic backpressure();
    logic [lce_data_width-1:0] d [3];
    lce_data_cmd_type_e        ty [3];
    int                        accepted;
    int                        base_cce;
    int                        base_tr;
    int                        waited;
    logic                      ready_seen;
    logic [data_width-1:0]     got;
    for (int i = 0; i < 3; i++) d[i] = rand_block();
    ty[0] = e_lce_data_cmd_cce;
    ty[1] = e_lce_data_cmd_transfer;
    ty[2] = e_lce_data_cmd_cce;
    accepted = 0;
    waited = 0;
    ready_seen = 1'b1;
    @(posedge clk);
    base_cce = cce_cnt;
    base_tr  = tr_cnt;
    miss_addr_i     <= make_addr(8'h02, bp_set, 2'd0);
    rd_v_i          <= 1'b1;
    rd_addr_i       <= make_addr(8'h00, fill_set, 2'd0);
    rd_way_i        <= '0;
    data_cmd_v_i    <= 1'b1;
    data_cmd_type_i <= ty[0];
    data_cmd_way_i  <= bp_way;
    data_cmd_data_i <= d[0];
    repeat (8) begin
      @(negedge clk);
      ready_seen = data_cmd_ready_o;
      if (ready_seen) accepted++;
      @(posedge clk);
      if (accepted < 3) begin
        data_cmd_type_i <= ty[accepted];
        data_cmd_data_i <= d[accepted];
      end
    end
    if (accepted != 2) report_mismatch("accepted messages", 2, accepted);
    if (ready_seen !== 1'b0) report_mismatch("data_cmd_ready_o", 0, ready_seen);
    if (cce_cnt != base_cce || tr_cnt != base_tr) begin
      errors++;
      $display("ERROR: received pulse while fills were stalled, t=%0t", $time);
    end
    // release the port; the third message goes in once a slot frees up.
    rd_v_i <= 1'b0;
    @(negedge clk);
    while (!data_cmd_ready_o && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (!data_cmd_ready_o) begin
      errors++;
      $display("ERROR: third message not accepted after release, t=%0t", $time);
    end
    @(posedge clk);
    data_cmd_v_i <= 1'b0;
    wait_drain();
    if (cce_cnt - base_cce != 2) report_mismatch("cce pulse count", 2, cce_cnt - base_cce);
    if (tr_cnt - base_tr != 1) report_mismatch("tr pulse count", 1, tr_cnt - base_tr);
    for (int k = 0; k < ways; k++) begin
      read_word(bp_set, bp_way, word_offset_width'(k), got);
      if (got !== d[2][k*data_width +: data_width]) begin
        report_mismatch("rd_data_o", d[2][k*data_width +: data_width], got);
      end
    end
  endtask

  task automatic random_mix();
    logic [31:0]            r;
    logic [data_width-1:0]  got;
    logic [index_width-1:0] set;
    logic [way_width-1:0]   way;
    repeat (40) begin
      r = next_rand();
      // upper bits pick the action, the low LCG bits only step through a short cycle.
      case (r[31:30])
        2'd0: begin
          wait_drain();
          @(posedge clk);
          miss_addr_i <= make_addr(r[15:8], r[19:16], r[21:20]);
        end
        2'd1, 2'd2: send_msg(lce_data_cmd_type_e'(r[8]), r[10:9], rand_block());
        default: begin
          set = r[11:8];
          way = r[13:12];
          if (!written[set][way]) begin
            set = fill_set;
            way = '0;
          end
          read_word(set, way, r[15:14], got);
        end
      endcase
    end
    wait_drain();
  endtask

  initial begin
    errors          = 0;
    cce_cnt         = 0;
    tr_cnt          = 0;
    seed            = 32'h1a55;
    prev_rd_v       = 1'b0;
    exp_word        = '0;
    reset_i         = 1'b1;
    miss_addr_i     = '0;
    data_cmd_type_i = e_lce_data_cmd_transfer;
    data_cmd_way_i  = '0;
    data_cmd_data_i = '0;
    data_cmd_v_i    = 1'b0;
    rd_v_i          = 1'b0;
    rd_addr_i       = '0;
    rd_way_i        = '0;
    repeat (reset_cycles) @(posedge clk);
    reset_i <= 1'b0;
    check_reset();
    fill_and_readback();
    count_flags();
    backpressure();
    random_mix();
    @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // ends a hung run.
  initial begin
    #((test_cycles * 4 + reset_cycles) * 8);
    $display("ERROR: watchdog expired before the tests finished");
    $display("errors: %0d", errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
